// File: hw/tproc_cfg.svh
////////////////////////////////////////////////////////////
// Port index and FIFO address widths must match the port
// count and depth below; the full flag sits at depth minus 2
////////////////////////////////////////////////////////////

`ifndef TPROC_CFG_SVH
`define TPROC_CFG_SVH

// Absolute time and stamp width
`define TPROC_TIME_W    48

// Output data port payload
`define TPROC_DATA_W    32

// Output data ports and their index width
`define TPROC_DPORT_QTY 4
`define TPROC_PORT_AW   2

// Per port FIFO, depth is 2**AW
`define TPROC_FIFO_AW   3

`endif

// File: hw/tproc_port_pkg.sv
////////////////////////////////////////////////////////////
// Timed port data types, widths come from the cfg header
////////////////////////////////////////////////////////////

`default_nettype none

`include "tproc_cfg.svh"

package tproc_port_pkg;

   // Absolute time, also used for stamps and offsets
   typedef logic [`TPROC_TIME_W-1:0] time_t;

   // Output port payload
   typedef logic [`TPROC_DATA_W-1:0] data_t;

   // Output data port select
   typedef logic [`TPROC_PORT_AW-1:0] port_idx_t;

endpackage

`default_nettype wire

// File: hw/tproc_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Processor control encodings, state values are reported
// on the top level state output
////////////////////////////////////////////////////////////

`default_nettype none

package tproc_ctrl_pkg;

   // Processor state machine
   typedef enum logic [2:0] {
      T_RST  = 3'd0,
      P_RST  = 3'd1,
      T_INIT = 3'd2,
      STOP   = 3'd3,
      PLAY   = 3'd4,
      PAUSE  = 3'd5,
      UPDATE = 3'd6
   } proc_state_t;

   // External command port opcodes
   typedef enum logic [1:0] {
      CMD_PORT_WR = 2'd0,
      CMD_REF_SET = 2'd1,
      CMD_REF_INC = 2'd2
   } cmd_op_t;

endpackage

`default_nettype wire

// File: hw/tproc_ctrl.sv
////////////////////////////////////////////////////////////
// Strobes are registered, so a strobe acts one edge later
// Offset is only valid after an init or update strobe
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tproc_cfg.svh"

module tproc_ctrl (
   input  wire                               c_clk_i,
   input  wire                               c_rst_ni,
   input  wire                               proc_rst_i,
   input  wire                               proc_run_i,
   input  wire                               proc_stop_i,
   input  wire                               proc_pause_i,
   input  wire                               time_rst_i,
   input  wire                               time_init_i,
   input  wire                               time_updt_i,
   input  wire tproc_port_pkg::time_t        offset_dt_i,
   input  wire                               any_full_i,
   output logic                              time_en_o,
   output logic                              time_rst_o,
   output logic                              time_init_o,
   output logic                              time_updt_o,
   output tproc_port_pkg::time_t             offset_o,
   output logic                              proc_rst_o,
   output logic                              core_en_o,
   output tproc_ctrl_pkg::proc_state_t       state_o
);

   tproc_ctrl_pkg::proc_state_t state_q;
   tproc_ctrl_pkg::proc_state_t state_d;
   logic p_rst_q, p_run_q, p_stop_q, p_pause_q;
   logic t_rst_q, t_init_q, t_updt_q;
   logic run_st;

   // STROBE CAPTURE
   ////////////////////////////////////////////////////////////
   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         p_rst_q   <= 1'b0;
         p_run_q   <= 1'b0;
         p_stop_q  <= 1'b0;
         p_pause_q <= 1'b0;
         t_rst_q   <= 1'b0;
         t_init_q  <= 1'b0;
         t_updt_q  <= 1'b0;
      end else begin
         p_rst_q   <= proc_rst_i;
         p_run_q   <= proc_run_i;
         p_stop_q  <= proc_stop_i;
         p_pause_q <= proc_pause_i;
         t_rst_q   <= time_rst_i;
         t_init_q  <= time_init_i;
         t_updt_q  <= time_updt_i;
      end
   end

   // Offset follows the strobe that will use it
   always_ff @(posedge c_clk_i) begin
      if (time_init_i || time_updt_i) begin
         offset_o <= offset_dt_i;
      end
   end

   // STATE MACHINE
   ////////////////////////////////////////////////////////////
   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         state_q <= tproc_ctrl_pkg::T_RST;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      // One cycle states move on by themselves
      case (state_q)
         tproc_ctrl_pkg::T_RST:  state_d = tproc_ctrl_pkg::P_RST;
         tproc_ctrl_pkg::P_RST:  state_d = tproc_ctrl_pkg::STOP;
         tproc_ctrl_pkg::T_INIT: state_d = tproc_ctrl_pkg::PLAY;
         tproc_ctrl_pkg::UPDATE: state_d = tproc_ctrl_pkg::PLAY;
         default:                state_d = state_q;
      endcase
      // Strobe priority, highest first
      if (p_rst_q) begin
         state_d = tproc_ctrl_pkg::P_RST;
      end else if (t_rst_q) begin
         state_d = tproc_ctrl_pkg::T_RST;
      end else if (t_init_q) begin
         state_d = tproc_ctrl_pkg::T_INIT;
      end else if (p_stop_q) begin
         state_d = tproc_ctrl_pkg::STOP;
      end else if (p_run_q) begin
         state_d = tproc_ctrl_pkg::PLAY;
      end else if (t_updt_q) begin
         state_d = tproc_ctrl_pkg::UPDATE;
      end else if (p_pause_q) begin
         state_d = tproc_ctrl_pkg::PAUSE;
      end
   end

   // State decode
   always_comb begin
      time_en_o   = 1'b0;
      time_rst_o  = 1'b0;
      time_init_o = 1'b0;
      time_updt_o = 1'b0;
      proc_rst_o  = 1'b0;
      run_st      = 1'b0;
      case (state_q)
         tproc_ctrl_pkg::T_RST: time_rst_o = 1'b1;
         tproc_ctrl_pkg::P_RST: proc_rst_o = 1'b1;
         tproc_ctrl_pkg::T_INIT: begin
            proc_rst_o  = 1'b1;
            time_init_o = 1'b1;
         end
         tproc_ctrl_pkg::PLAY: begin
            time_en_o = 1'b1;
            run_st    = 1'b1;
         end
         tproc_ctrl_pkg::PAUSE: time_en_o = 1'b1;
         tproc_ctrl_pkg::UPDATE: begin
            time_updt_o = 1'b1;
            time_en_o   = 1'b1;
            run_st      = 1'b1;
         end
         default: run_st = 1'b0;
      endcase
   end

   // Blocking mode, any full FIFO stalls the command source
   assign core_en_o = run_st & ~any_full_i;
   assign state_o   = state_q;

   // Time counter sees at most one load command per cycle
   assert property (@(posedge c_clk_i) disable iff (!c_rst_ni)
      $onehot0({time_rst_o, time_init_o, time_updt_o}));

endmodule

`default_nettype wire

// File: hw/tproc_time.sv
////////////////////////////////////////////////////////////
// Counter wraps silently at 2**48
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tproc_cfg.svh"

module tproc_time (
   input  wire                         c_clk_i,
   input  wire                         c_rst_ni,
   input  wire                         time_en_i,
   input  wire                         time_rst_i,
   input  wire                         time_init_i,
   input  wire                         time_updt_i,
   input  wire tproc_port_pkg::time_t  offset_i,
   output tproc_port_pkg::time_t       time_abs_o
);

   tproc_port_pkg::time_t time_q;

   // Reset, load, add, then free running count
   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         time_q <= '0;
      end else if (time_rst_i) begin
         time_q <= '0;
      end else if (time_init_i) begin
         time_q <= offset_i;
      end else if (time_updt_i) begin
         time_q <= time_q + offset_i;
      end else if (time_en_i) begin
         time_q <= time_q + tproc_port_pkg::time_t'(1);
      end
   end

   assign time_abs_o = time_q;

endmodule

`default_nettype wire

// File: hw/tproc_cmd_stage.sv
////////////////////////////////////////////////////////////
// Commands offered while core_en_i is low are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tproc_cfg.svh"

module tproc_cmd_stage (
   input  wire                              c_clk_i,
   input  wire                              c_rst_ni,
   input  wire                              proc_rst_i,
   input  wire                              core_en_i,
   input  wire                              cmd_valid_i,
   input  wire tproc_ctrl_pkg::cmd_op_t     cmd_op_i,
   input  wire tproc_port_pkg::port_idx_t   cmd_port_i,
   input  wire tproc_port_pkg::time_t       cmd_time_i,
   input  wire tproc_port_pkg::data_t       cmd_data_i,
   output logic [`TPROC_DPORT_QTY-1:0]      push_o,
   output tproc_port_pkg::time_t            stamp_o,
   output tproc_port_pkg::data_t            data_o
);

   tproc_port_pkg::time_t ref_q;
   logic cmd_acc;

   assign cmd_acc = cmd_valid_i & core_en_i;

   // Time reference
   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         ref_q <= '0;
      end else if (proc_rst_i) begin
         ref_q <= '0;
      end else if (cmd_acc) begin
         case (cmd_op_i)
            tproc_ctrl_pkg::CMD_REF_SET: ref_q <= cmd_time_i;
            tproc_ctrl_pkg::CMD_REF_INC: ref_q <= ref_q + cmd_time_i;
            default:                     ref_q <= ref_q;
         endcase
      end
   end

   // One-hot push toward the port FIFOs
   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         push_o <= '0;
      end else begin
         push_o <= '0;
         if (cmd_acc && cmd_op_i == tproc_ctrl_pkg::CMD_PORT_WR) begin
            push_o[cmd_port_i] <= 1'b1;
         end
      end
   end

   // Stamp is relative time plus the reference at acceptance
   always_ff @(posedge c_clk_i) begin
      if (cmd_acc) begin
         stamp_o <= cmd_time_i + ref_q;
         data_o  <= cmd_data_i;
      end
   end

endmodule

`default_nettype wire

// File: hw/tproc_port_fifo.sv
////////////////////////////////////////////////////////////
// Full rises two entries early to absorb the push pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tproc_port_fifo #(
   parameter int DW = 80,
   parameter int AW = 3
) (
   input  wire            c_clk_i,
   input  wire            c_rst_ni,
   input  wire            flush_i,
   input  wire            push_i,
   input  wire [DW-1:0]   data_i,
   input  wire            pop_i,
   output logic [DW-1:0]  data_o,
   output logic           empty_o,
   output logic           full_o
);

   localparam int DEPTH = 1 << AW;
   localparam logic [AW:0] FULL_LVL = (AW+1)'(DEPTH - 2);

   logic [DW-1:0] mem [DEPTH];
   logic [AW-1:0] wr_ptr, rd_ptr;
   logic [AW:0]   count;
   logic          full_true, do_push, do_pop;

   // Top count bit only set at exactly DEPTH entries
   assign full_true = count[AW];
   assign do_push   = push_i & ~full_true;
   assign do_pop    = pop_i & ~empty_o;

   always_ff @(posedge c_clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head word is visible without a pop
   assign data_o  = mem[rd_ptr];
   assign empty_o = (count == '0);
   assign full_o  = (count >= FULL_LVL);

   // Back-pressure upstream must keep the last two slots free
   assert property (@(posedge c_clk_i) disable iff (!c_rst_ni || flush_i)
      push_i |-> !full_true);
   assert property (@(posedge c_clk_i) disable iff (!c_rst_ni || flush_i)
      pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: hw/tproc_port_disp.sv
////////////////////////////////////////////////////////////
// Items leave one cycle after time reaches their stamp
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tproc_cfg.svh"

module tproc_port_disp (
   input  wire                         c_clk_i,
   input  wire                         c_rst_ni,
   input  wire                         proc_rst_i,
   input  wire                         time_en_i,
   input  wire tproc_port_pkg::time_t  time_abs_i,
   input  wire                         push_i,
   input  wire tproc_port_pkg::time_t  stamp_i,
   input  wire tproc_port_pkg::data_t  data_i,
   output logic                        tvalid_o,
   output tproc_port_pkg::data_t       tdata_o,
   output logic                        empty_o,
   output logic                        full_o
);

   localparam int FIFO_DW = `TPROC_DATA_W + `TPROC_TIME_W;

   logic [FIFO_DW-1:0]    head;
   tproc_port_pkg::time_t head_stamp;
   tproc_port_pkg::data_t head_data;
   logic                  pop;

   tproc_port_fifo #(
      .DW (FIFO_DW),
      .AW (`TPROC_FIFO_AW)
   ) fifo_inst (
      .c_clk_i  (c_clk_i),
      .c_rst_ni (c_rst_ni),
      .flush_i  (proc_rst_i),
      .push_i   (push_i),
      .data_i   ({data_i, stamp_i}),
      .pop_i    (pop),
      .data_o   (head),
      .empty_o  (empty_o),
      .full_o   (full_o)
   );

   assign {head_data, head_stamp} = head;

   // Pop once time has reached the head stamp
   assign pop = ~empty_o & time_en_i & (time_abs_i >= head_stamp);

   always_ff @(posedge c_clk_i or negedge c_rst_ni) begin
      if (!c_rst_ni) begin
         tvalid_o <= 1'b0;
      end else begin
         tvalid_o <= pop;
      end
   end

   // Data holds until the next pulse
   always_ff @(posedge c_clk_i) begin
      if (pop) begin
         tdata_o <= head_data;
      end
   end

endmodule

`default_nettype wire

// File: hw/tproc_top.sv
////////////////////////////////////////////////////////////
// Single clock; drive cmd_valid_i only while core_en_o is high
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tproc_cfg.svh"

module tproc_top (
   input  wire                              c_clk_i,
   input  wire                              c_rst_ni,
   input  wire                              proc_rst_i,
   input  wire                              proc_run_i,
   input  wire                              proc_stop_i,
   input  wire                              proc_pause_i,
   input  wire                              time_rst_i,
   input  wire                              time_init_i,
   input  wire                              time_updt_i,
   input  wire tproc_port_pkg::time_t       offset_dt_i,
   input  wire                              cmd_valid_i,
   input  wire tproc_ctrl_pkg::cmd_op_t     cmd_op_i,
   input  wire tproc_port_pkg::port_idx_t   cmd_port_i,
   input  wire tproc_port_pkg::time_t       cmd_time_i,
   input  wire tproc_port_pkg::data_t       cmd_data_i,
   output tproc_port_pkg::time_t            t_time_abs_o,
   output tproc_ctrl_pkg::proc_state_t      proc_state_o,
   output wire                              core_en_o,
   output wire [`TPROC_DPORT_QTY-1:0]       fifo_full_o,
   output wire [`TPROC_DPORT_QTY-1:0]       fifo_empty_o,
   output wire [`TPROC_DPORT_QTY-1:0]       port_tvalid_o,
   output tproc_port_pkg::data_t            port_tdata_o [`TPROC_DPORT_QTY]
);

   wire time_en, time_rst, time_init, time_updt;
   wire proc_rst, core_en;
   tproc_port_pkg::time_t offset;
   tproc_port_pkg::time_t stamp;
   tproc_port_pkg::data_t data;
   wire [`TPROC_DPORT_QTY-1:0] push;

   // CONTROL AND TIME
   ////////////////////////////////////////////////////////////
   tproc_ctrl ctrl_inst (
      .c_clk_i      (c_clk_i),
      .c_rst_ni     (c_rst_ni),
      .proc_rst_i   (proc_rst_i),
      .proc_run_i   (proc_run_i),
      .proc_stop_i  (proc_stop_i),
      .proc_pause_i (proc_pause_i),
      .time_rst_i   (time_rst_i),
      .time_init_i  (time_init_i),
      .time_updt_i  (time_updt_i),
      .offset_dt_i  (offset_dt_i),
      .any_full_i   (|fifo_full_o),
      .time_en_o    (time_en),
      .time_rst_o   (time_rst),
      .time_init_o  (time_init),
      .time_updt_o  (time_updt),
      .offset_o     (offset),
      .proc_rst_o   (proc_rst),
      .core_en_o    (core_en),
      .state_o      (proc_state_o)
   );

   tproc_time time_inst (
      .c_clk_i     (c_clk_i),
      .c_rst_ni    (c_rst_ni),
      .time_en_i   (time_en),
      .time_rst_i  (time_rst),
      .time_init_i (time_init),
      .time_updt_i (time_updt),
      .offset_i    (offset),
      .time_abs_o  (t_time_abs_o)
   );

   assign core_en_o = core_en;

   // COMMANDS AND PORTS
   ////////////////////////////////////////////////////////////
   tproc_cmd_stage cmd_inst (
      .c_clk_i     (c_clk_i),
      .c_rst_ni    (c_rst_ni),
      .proc_rst_i  (proc_rst),
      .core_en_i   (core_en),
      .cmd_valid_i (cmd_valid_i),
      .cmd_op_i    (cmd_op_i),
      .cmd_port_i  (cmd_port_i),
      .cmd_time_i  (cmd_time_i),
      .cmd_data_i  (cmd_data_i),
      .push_o      (push),
      .stamp_o     (stamp),
      .data_o      (data)
   );

   for (genvar i = 0; i < `TPROC_DPORT_QTY; i++) begin : g_port
      tproc_port_disp disp_inst (
         .c_clk_i    (c_clk_i),
         .c_rst_ni   (c_rst_ni),
         .proc_rst_i (proc_rst),
         .time_en_i  (time_en),
         .time_abs_i (t_time_abs_o),
         .push_i     (push[i]),
         .stamp_i    (stamp),
         .data_i     (data),
         .tvalid_o   (port_tvalid_o[i]),
         .tdata_o    (port_tdata_o[i]),
         .empty_o    (fifo_empty_o[i]),
         .full_o     (fifo_full_o[i])
      );
   end

endmodule

`default_nettype wire

// File: testbench/tb_tproc_checker.sv
////////////////////////////////////////////////////////////
// Samples on the rising edge and models pending items per port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tproc_cfg.svh"

module tb_tproc_checker (
   input  wire                              c_clk_i,
   input  wire                              c_rst_ni,
   input  wire                              cmd_valid_i,
   input  wire tproc_ctrl_pkg::cmd_op_t     cmd_op_i,
   input  wire tproc_port_pkg::port_idx_t   cmd_port_i,
   input  wire tproc_port_pkg::time_t       cmd_time_i,
   input  wire tproc_port_pkg::data_t       cmd_data_i,
   input  wire                              core_en_i,
   input  wire tproc_ctrl_pkg::proc_state_t state_i,
   input  wire tproc_port_pkg::time_t       time_abs_i,
   input  wire [`TPROC_DPORT_QTY-1:0]       tvalid_i,
   input  wire tproc_port_pkg::data_t       tdata_i [`TPROC_DPORT_QTY],
   output int                               pending_o
);

   localparam int IW = `TPROC_TIME_W + `TPROC_DATA_W;

   // Items as {stamp, data}, in push order
   logic [IW-1:0] exp_q [`TPROC_DPORT_QTY][$];
   tproc_port_pkg::time_t ref_m = '0;
   string test_name = "reset";
   int check_cnt    = 0;
   int mismatch_cnt = 0;
   int error_cnt    = 0;

   task automatic set_test(input string name);
      test_name = name;
   endtask

   task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
      check_cnt++;
      if (exp !== act) begin
         mismatch_cnt++;
         $display("MISMATCH test=%s item=%s expected=%0h actual=%0h",
                  test_name, what, exp, act);
      end
   endtask

   task automatic report_error(input string msg);
      error_cnt++;
      $display("ERROR test=%s %s", test_name, msg);
   endtask

   task automatic check_pulse(input int p);
      logic [IW-1:0]         item;
      tproc_port_pkg::time_t stamp;
      tproc_port_pkg::data_t data;
      if (exp_q[p].size() == 0) begin
         report_error($sformatf("unexpected output pulse on port %0d at time %0h",
                                p, time_abs_i));
      end else begin
         item = exp_q[p].pop_front();
         {stamp, data} = item;
         compare($sformatf("port %0d data", p), data, tdata_i[p]);
         if (time_abs_i <= stamp) begin
            report_error($sformatf("port %0d pulse at time %0h is not after stamp %0h",
                                   p, time_abs_i, stamp));
         end
      end
   endtask

   // Model of the reference register and the per port queues
   task automatic accept_cmd();
      case (cmd_op_i)
         tproc_ctrl_pkg::CMD_PORT_WR: begin
            exp_q[cmd_port_i].push_back({cmd_time_i + ref_m, cmd_data_i});
         end
         tproc_ctrl_pkg::CMD_REF_SET: ref_m = cmd_time_i;
         tproc_ctrl_pkg::CMD_REF_INC: ref_m = ref_m + cmd_time_i;
         default: report_error("command with an unknown opcode was accepted");
      endcase
   endtask

   always @(posedge c_clk_i) begin
      if (c_rst_ni) begin
         for (int p = 0; p < `TPROC_DPORT_QTY; p++) begin
            if (tvalid_i[p]) begin
               check_pulse(p);
            end
         end
         if (cmd_valid_i && core_en_i) begin
            accept_cmd();
         end
         // Processor reset drops everything queued
         if (state_i == tproc_ctrl_pkg::P_RST || state_i == tproc_ctrl_pkg::T_INIT) begin
            for (int p = 0; p < `TPROC_DPORT_QTY; p++) begin
               exp_q[p].delete();
            end
            ref_m = '0;
         end
      end
      pending_o = 0;
      for (int p = 0; p < `TPROC_DPORT_QTY; p++) begin
         pending_o = pending_o + exp_q[p].size();
      end
   end

endmodule

`default_nettype wire

// File: testbench/tb_tproc.sv
////////////////////////////////////////////////////////////
// Inputs change on the falling edge, commands wait for core_en_o
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "tproc_cfg.svh"

module tb_tproc;

   // Strobe bit positions
   localparam int S_PRST  = 0;
   localparam int S_RUN   = 1;
   localparam int S_STOP  = 2;
   localparam int S_PAUSE = 3;
   localparam int S_TRST  = 4;
   localparam int S_TINIT = 5;
   localparam int S_TUPDT = 6;

   localparam int WAIT_SHORT = 16;
   localparam int WAIT_LONG  = 4000;
   localparam int NROWS      = 26;

   typedef struct packed {
      tproc_ctrl_pkg::cmd_op_t   op;
      tproc_port_pkg::port_idx_t port;
      tproc_port_pkg::time_t     t;
      tproc_port_pkg::data_t     data;
      logic                      rnd;
   } stim_row_t;

   logic                          c_clk;
   logic                          c_rst_n;
   logic [6:0]                    strb;
   tproc_port_pkg::time_t         offset_dt;
   logic                          cmd_valid;
   tproc_ctrl_pkg::cmd_op_t       cmd_op;
   tproc_port_pkg::port_idx_t     cmd_port;
   tproc_port_pkg::time_t         cmd_time;
   tproc_port_pkg::data_t         cmd_data;
   tproc_port_pkg::time_t         t_time_abs;
   tproc_ctrl_pkg::proc_state_t   proc_state;
   wire                           core_en;
   wire [`TPROC_DPORT_QTY-1:0]    fifo_full;
   wire [`TPROC_DPORT_QTY-1:0]    fifo_empty;
   wire [`TPROC_DPORT_QTY-1:0]    port_tvalid;
   tproc_port_pkg::data_t         port_tdata [`TPROC_DPORT_QTY];
   int                            pending;
   stim_row_t                     tbl [NROWS];
   logic [`TPROC_DPORT_QTY-1:0]   full_seen;
   tproc_port_pkg::time_t         t0;

   tproc_top tproc_top_inst (
      .c_clk_i       (c_clk),
      .c_rst_ni      (c_rst_n),
      .proc_rst_i    (strb[S_PRST]),
      .proc_run_i    (strb[S_RUN]),
      .proc_stop_i   (strb[S_STOP]),
      .proc_pause_i  (strb[S_PAUSE]),
      .time_rst_i    (strb[S_TRST]),
      .time_init_i   (strb[S_TINIT]),
      .time_updt_i   (strb[S_TUPDT]),
      .offset_dt_i   (offset_dt),
      .cmd_valid_i   (cmd_valid),
      .cmd_op_i      (cmd_op),
      .cmd_port_i    (cmd_port),
      .cmd_time_i    (cmd_time),
      .cmd_data_i    (cmd_data),
      .t_time_abs_o  (t_time_abs),
      .proc_state_o  (proc_state),
      .core_en_o     (core_en),
      .fifo_full_o   (fifo_full),
      .fifo_empty_o  (fifo_empty),
      .port_tvalid_o (port_tvalid),
      .port_tdata_o  (port_tdata)
   );

   tb_tproc_checker chk_inst (
      .c_clk_i     (c_clk),
      .c_rst_ni    (c_rst_n),
      .cmd_valid_i (cmd_valid),
      .cmd_op_i    (cmd_op),
      .cmd_port_i  (cmd_port),
      .cmd_time_i  (cmd_time),
      .cmd_data_i  (cmd_data),
      .core_en_i   (core_en),
      .state_i     (proc_state),
      .time_abs_i  (t_time_abs),
      .tvalid_i    (port_tvalid),
      .tdata_i     (port_tdata),
      .pending_o   (pending)
   );

   initial begin
      c_clk = 1'b0;
      forever #10 c_clk = ~c_clk;
   end

   // STIMULUS TABLE
   ////////////////////////////////////////////////////////////
   task automatic load_table();
      // Timed writes with reference moves between them
      tbl[0]  = '{tproc_ctrl_pkg::CMD_REF_SET, 2'd0, 48'h1600, 32'h0, 1'b0};
      tbl[1]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd0, 48'h10, 32'hA000_0001, 1'b0};
      tbl[2]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd1, 48'h12, 32'h0, 1'b1};
      tbl[3]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd2, 48'h14, 32'hA000_0003, 1'b0};
      tbl[4]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd0, 48'h20, 32'h0, 1'b1};
      tbl[5]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd3, 48'h20, 32'hA000_0005, 1'b0};
      tbl[6]  = '{tproc_ctrl_pkg::CMD_REF_INC, 2'd0, 48'h40, 32'h0, 1'b0};
      tbl[7]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd1, 48'h00, 32'hB000_0001, 1'b0};
      tbl[8]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd2, 48'h08, 32'h0, 1'b1};
      tbl[9]  = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd3, 48'h08, 32'hB000_0003, 1'b0};
      tbl[10] = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd0, 48'h10, 32'hB000_0004, 1'b0};
      tbl[11] = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd1, 48'h18, 32'h0, 1'b1};
      // Eight far writes to port 2
      tbl[12] = '{tproc_ctrl_pkg::CMD_REF_INC, 2'd0, 48'h400, 32'h0, 1'b0};
      for (int i = 0; i < 8; i++) begin
         tbl[13+i] = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd2, 48'(i), 32'hC000_0000 + 32'(i),
                       1'(i % 3 == 0)};
      end
      // Queued items that a processor reset must discard
      tbl[21] = '{tproc_ctrl_pkg::CMD_REF_INC, 2'd0, 48'h300, 32'h0, 1'b0};
      tbl[22] = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd0, 48'h00, 32'h0, 1'b1};
      tbl[23] = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd1, 48'h04, 32'hD000_0002, 1'b0};
      tbl[24] = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd2, 48'h08, 32'hD000_0003, 1'b0};
      tbl[25] = '{tproc_ctrl_pkg::CMD_PORT_WR, 2'd3, 48'h0C, 32'h0, 1'b1};
   endtask

   // DRIVER TASKS
   ////////////////////////////////////////////////////////////
   task automatic pulse(input int bit_idx);
      strb = '0;
      strb[bit_idx] = 1'b1;
      @(negedge c_clk);
      strb = '0;
   endtask

   task automatic wait_state(input tproc_ctrl_pkg::proc_state_t st, input int limit);
      int n;
      n = 0;
      while (proc_state !== st && n < limit) begin
         @(negedge c_clk);
         n++;
      end
      if (proc_state !== st) begin
         chk_inst.report_error($sformatf("timeout waiting for state %s", st.name()));
      end
   endtask

   task automatic send_cmd(input tproc_ctrl_pkg::cmd_op_t op,
                           input tproc_port_pkg::port_idx_t port,
                           input tproc_port_pkg::time_t t,
                           input tproc_port_pkg::data_t d);
      int n;
      n = 0;
      while (!core_en && n < WAIT_LONG) begin
         full_seen = full_seen | fifo_full;
         @(negedge c_clk);
         n++;
      end
      if (!core_en) begin
         chk_inst.report_error("timeout waiting for core_en_o before a command");
      end else begin
         cmd_valid = 1'b1;
         cmd_op    = op;
         cmd_port  = port;
         cmd_time  = t;
         cmd_data  = d;
         @(negedge c_clk);
         cmd_valid = 1'b0;
      end
   endtask

   task automatic apply_rows(input int first, input int last);
      tproc_port_pkg::data_t d;
      for (int i = first; i <= last; i++) begin
         d = tbl[i].rnd ? tproc_port_pkg::data_t'($urandom) : tbl[i].data;
         send_cmd(tbl[i].op, tbl[i].port, tbl[i].t, d);
      end
   endtask

   task automatic check_count(input string what, input int step, input int cycles);
      tproc_port_pkg::time_t t_start;
      t_start = t_time_abs;
      for (int k = 1; k <= cycles; k++) begin
         @(negedge c_clk);
         chk_inst.compare(what, t_start + tproc_port_pkg::time_t'(step * k), t_time_abs);
      end
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while ((pending != 0 || fifo_empty != '1) && n < limit) begin
         @(negedge c_clk);
         n++;
      end
      if (pending != 0 || fifo_empty != '1) begin
         chk_inst.report_error("timeout waiting for queued items to emerge");
      end
   endtask

   task automatic wait_time_past(input tproc_port_pkg::time_t t, input int limit);
      int n;
      n = 0;
      while (t_time_abs <= t && n < limit) begin
         @(negedge c_clk);
         n++;
      end
      if (t_time_abs <= t) begin
         chk_inst.report_error("timeout waiting for time to pass the discarded stamps");
      end
   endtask

   // RUN SEQUENCE
   ////////////////////////////////////////////////////////////
   initial begin
      c_rst_n   = 1'b0;
      strb      = '0;
      offset_dt = '0;
      cmd_valid = 1'b0;
      cmd_op    = tproc_ctrl_pkg::CMD_PORT_WR;
      cmd_port  = '0;
      cmd_time  = '0;
      cmd_data  = '0;
      full_seen = '0;
      void'($urandom(32'h8253));
      load_table();
      repeat (10) @(negedge c_clk);
      c_rst_n = 1'b1;

      chk_inst.set_test("reset");
      chk_inst.compare("state", tproc_ctrl_pkg::T_RST, proc_state);
      chk_inst.compare("time", 0, t_time_abs);
      chk_inst.compare("core_en", 0, core_en);
      @(negedge c_clk);
      chk_inst.compare("state", tproc_ctrl_pkg::P_RST, proc_state);
      @(negedge c_clk);
      chk_inst.compare("state", tproc_ctrl_pkg::STOP, proc_state);
      chk_inst.compare("time", 0, t_time_abs);
      chk_inst.compare("core_en", 0, core_en);

      chk_inst.set_test("run pause stop");
      pulse(S_RUN);
      wait_state(tproc_ctrl_pkg::PLAY, WAIT_SHORT);
      chk_inst.compare("core_en in PLAY", 1, core_en);
      check_count("run count", 1, 5);
      pulse(S_PAUSE);
      wait_state(tproc_ctrl_pkg::PAUSE, WAIT_SHORT);
      chk_inst.compare("core_en in PAUSE", 0, core_en);
      check_count("pause count", 1, 4);
      pulse(S_STOP);
      wait_state(tproc_ctrl_pkg::STOP, WAIT_SHORT);
      check_count("stop hold", 0, 4);

      chk_inst.set_test("init update");
      offset_dt = 48'h1000;
      pulse(S_TINIT);
      wait_state(tproc_ctrl_pkg::T_INIT, WAIT_SHORT);
      @(negedge c_clk);
      chk_inst.compare("state after init", tproc_ctrl_pkg::PLAY, proc_state);
      chk_inst.compare("init load", 48'h1000, t_time_abs);
      offset_dt = 48'h500;
      pulse(S_TUPDT);
      wait_state(tproc_ctrl_pkg::UPDATE, WAIT_SHORT);
      t0 = t_time_abs;
      @(negedge c_clk);
      chk_inst.compare("update add", t0 + 48'h500, t_time_abs);
      chk_inst.compare("state after update", tproc_ctrl_pkg::PLAY, proc_state);

      chk_inst.set_test("table writes");
      apply_rows(0, 11);
      wait_drain(WAIT_LONG);
      chk_inst.compare("fifo empty", 4'hF, fifo_empty);

      chk_inst.set_test("back-pressure");
      full_seen = '0;
      apply_rows(12, 20);
      chk_inst.compare("full ports while stalled", 4'b0100, full_seen);
      wait_drain(WAIT_LONG);
      chk_inst.compare("fifo empty", 4'hF, fifo_empty);

      chk_inst.set_test("proc reset");
      apply_rows(21, 25);
      pulse(S_PRST);
      // Every port holds one far item until the flush
      chk_inst.compare("fifo empty before flush", 4'h0, fifo_empty);
      wait_state(tproc_ctrl_pkg::P_RST, WAIT_SHORT);
      wait_state(tproc_ctrl_pkg::STOP, WAIT_SHORT);
      chk_inst.compare("fifo empty", 4'hF, fifo_empty);
      pulse(S_RUN);
      wait_state(tproc_ctrl_pkg::PLAY, WAIT_SHORT);
      wait_time_past(48'h1D60, WAIT_LONG);

      $display("Checks %0d, mismatches %0d, other errors %0d",
               chk_inst.check_cnt, chk_inst.mismatch_cnt, chk_inst.error_cnt);
      if (chk_inst.mismatch_cnt + chk_inst.error_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/tproc_port_pkg.sv
hw/tproc_ctrl_pkg.sv
hw/tproc_ctrl.sv
hw/tproc_time.sv
hw/tproc_cmd_stage.sv
hw/tproc_port_fifo.sv
hw/tproc_port_disp.sv
hw/tproc_top.sv
testbench/tb_tproc_checker.sv
testbench/tb_tproc.sv

// File: Makefile
.PHONY: run lint clean

run:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_tproc
	./obj_dir/Vtb_tproc | tee /dev/stderr | grep -x "No errors" > /dev/null

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module tproc_top

clean:
	rm -rf obj_dir
